// ==== flist.f ====
+incdir+verification
common/i8008_isa_pkg.sv
common/i8008_core_pkg.sv
common/core_ctrl_if.sv
hdl/alu.sv
datapath/program_counter.sv
datapath/i8008_datapath.sv
sequencer/i8008_sequencer.sv
hdl/i8008_top.sv
verification/tb_i8008.sv

// ==== Bender.yml ====
package:
  name: i8008_core

sources:
  - common/i8008_isa_pkg.sv
  - common/i8008_core_pkg.sv
  - common/core_ctrl_if.sv
  - hdl/alu.sv
  - datapath/program_counter.sv
  - datapath/i8008_datapath.sv
  - sequencer/i8008_sequencer.sv
  - hdl/i8008_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_i8008.sv

// ==== verification/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Test program, assembled into mem while the model steps through it
task automatic build_program();
  load_imm(REG_H, 8'h25);            // Writes land in page 0x25xx
  load_imm(REG_L, 8'($urandom));
  load_imm(REG_B, 8'($urandom));
  load_imm(REG_C, 8'($urandom));
  load_imm(REG_A, 8'($urandom));
  move_reg(REG_D, REG_B);
  store_reg(REG_D);
  move_reg(REG_E, REG_A);
  store_reg(REG_E);
  store_reg(REG_H);
  for (int op = 0; op < 8; op++) begin
    load_imm(REG_A, 8'($urandom));
    alu_exec(3'(op), REG_C, 1'b0);   // Register operand
    store_reg(REG_A);
    alu_exec(3'(op), REG_C, 1'b1);   // Immediate operand
    store_reg(REG_A);
  end
  step_reg(REG_B, 1'b0);
  step_reg(REG_C, 1'b1);
  store_reg(REG_B);
  store_reg(REG_C);
  load_imm(REG_D, 8'hff);
  step_reg(REG_D, 1'b0);             // Wraps to zero
  store_reg(REG_D);
  load_imm(REG_E, 8'h00);
  step_reg(REG_E, 1'b1);
  store_reg(REG_E);
  alu_exec(ALU_ADC, REG_A, 1'b1);    // Carry must have survived INr and DCr
  store_reg(REG_A);
  for (int k = 0; k < 4; k++) begin
    rotate_acc(2'(k));
    store_reg(REG_A);
    alu_exec(ALU_ADC, REG_A, 1'b1);  // Makes the rotate carry visible
    store_reg(REG_A);
  end
  jump_to(14'h2a5c);
  load_imm(REG_B, 8'($urandom));
  store_reg(REG_B);
  halt_core();
endtask

`endif

// ==== verification/tb_i8008.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i8008;
  import i8008_core_pkg::*;
  import i8008_isa_pkg::*;

  localparam int          MEM_SIZE  = 1 << ADDR_W;
  localparam int          MAX_STALL = 4;
  localparam logic [31:0] SEED      = 32'h8fb0_8a1a;

  logic              clk;
  logic              rst;
  logic              ready;
  logic              sync;
  logic [DATA_W-1:0] d_in;
  logic [DATA_W-1:0] d_out;
  state_t            state;

  logic [DATA_W-1:0] mem [MEM_SIZE];
  logic [DATA_W-1:0] model_regs [NUM_REGS];
  logic              model_carry = 1'b0;
  logic [ADDR_W-1:0] next_addr = '0;   // Assembly pointer
  logic [15:0]       bus_q [$];        // Expected {cycle type, address} per machine cycle
  logic [DATA_W-1:0] data_q [$];       // Expected write data

  logic [DATA_W-1:0] addr_lo;
  logic [ADDR_W-1:0] cur_addr;
  logic [1:0]        cur_kind;
  bit                stalled;
  int                stall_len;
  int                waited;
  int                errors  = 0;
  int                checks  = 0;
  int                n_instr = 0;
  int                cycles  = 0;
  int                limit   = 0;

  i8008_top UUT (
    .clk   (clk),
    .rst   (rst),
    .d_in  (d_in),
    .ready (ready),
    .d_out (d_out),
    .sync  (sync),
    .state (state)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic expect_eq(input string what, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic put_byte(input logic [1:0] kind, input logic [DATA_W-1:0] value);
    bus_q.push_back({kind, next_addr});
    if (kind == CYC_PCI) n_instr++;
    mem[next_addr] = value;
    next_addr      = next_addr + 1'b1;
  endtask

  task automatic load_imm(input logic [2:0] r, input logic [DATA_W-1:0] value);
    put_byte(CYC_PCI, {2'b00, r, 3'b110});
    put_byte(CYC_PCR, value);
    model_regs[r] = value;
  endtask

  task automatic move_reg(input logic [2:0] dst, input logic [2:0] src);
    put_byte(CYC_PCI, {2'b11, dst, src});
    model_regs[dst] = model_regs[src];
  endtask

  task automatic alu_exec(input logic [2:0] op, input logic [2:0] src, input bit imm);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    int                t;
    a = model_regs[REG_A];
    if (imm) begin
      b = 8'($urandom);
      put_byte(CYC_PCI, {2'b00, op, 3'b100});
      put_byte(CYC_PCR, b);
    end else begin
      b = model_regs[src];
      put_byte(CYC_PCI, {2'b10, op, src});
    end
    case (op)
      ALU_ADD, ALU_ADC: begin
        t           = int'(a) + int'(b) + ((op == ALU_ADC) ? int'(model_carry) : 0);
        model_carry = (t > 255);
      end
      ALU_SUB, ALU_SBB, ALU_CMP: begin
        t           = int'(a) - int'(b) - ((op == ALU_SBB) ? int'(model_carry) : 0);
        model_carry = (t < 0);          // Borrow
      end
      default: begin
        t = (op == ALU_ANA) ? int'(a & b) : (op == ALU_XRA) ? int'(a ^ b) : int'(a | b);
        model_carry = 1'b0;
      end
    endcase
    if (op != ALU_CMP) model_regs[REG_A] = t[7:0];
  endtask

  task automatic step_reg(input logic [2:0] r, input bit dec);
    put_byte(CYC_PCI, {2'b00, r, 2'b00, dec});
    model_regs[r] = dec ? model_regs[r] - 8'd1 : model_regs[r] + 8'd1;
  endtask

  // Kind 0..3 is RLC, RRC, RAL, RAR
  task automatic rotate_acc(input logic [1:0] kind);
    logic [DATA_W-1:0] a;
    logic              c;
    a = model_regs[REG_A];
    c = model_carry;
    put_byte(CYC_PCI, {3'b000, kind, 3'b010});
    if (!kind[0]) begin
      model_regs[REG_A] = {a[6:0], kind[1] ? c : a[7]};
      model_carry       = a[7];
    end else begin
      model_regs[REG_A] = {kind[1] ? c : a[0], a[7:1]};
      model_carry       = a[0];
    end
  endtask

  task automatic store_reg(input logic [2:0] src);
    put_byte(CYC_PCI, {5'b11111, src});
    bus_q.push_back({CYC_PCW, model_regs[REG_H][ADDR_HI_W-1:0], model_regs[REG_L]});
    data_q.push_back(model_regs[src]);
  endtask

  task automatic jump_to(input logic [ADDR_W-1:0] target);
    put_byte(CYC_PCI, 8'h44);
    put_byte(CYC_PCR, target[7:0]);
    put_byte(CYC_PCR, {2'b00, target[ADDR_W-1:DATA_W]});
    next_addr = target;
  endtask

  task automatic halt_core();
    put_byte(CYC_PCI, 8'hff);
  endtask

  `include "tb_program.svh"

  // Memory model answering each state once the outputs settle
  task automatic bus_step();
    case (state)
      T1: begin
        addr_lo   = d_out;
        stalled   = ($urandom % 4) == 0;
        stall_len = 1 + ($urandom % MAX_STALL);
        waited    = 0;
        ready     = !stalled;  // Reaches the core two clocks later in T3
      end
      T2: begin
        cur_kind = d_out[7:6];
        cur_addr = {d_out[ADDR_HI_W-1:0], addr_lo};
        d_in     = stalled ? ~mem[cur_addr] : mem[cur_addr]; // Wrong byte until ready returns
        if (bus_q.size() == 0) begin
          errors++;
          $display("Unexpected bus cycle at %0t after the program ended", $time);
        end else begin
          expect_eq("cycle type and address", {cur_kind, cur_addr}, bus_q.pop_front());
        end
      end
      T3: begin
        if (cur_kind == CYC_PCW) begin
          if (data_q.size() == 0) begin
            errors++;
            $display("Write cycle at %0t has no expected data", $time);
          end else begin
            expect_eq("write data", d_out, data_q.pop_front());
          end
        end
      end
      WAIT: begin
        waited++;
        if (waited >= stall_len) begin
          ready = 1'b1;
          d_in  = mem[cur_addr];
        end
      end
      default: ;
    endcase
  endtask

  always @(posedge clk) begin
    #1;
    bus_step();
  end

  assert property (@(posedge clk) disable iff (rst)
    (state inside {T3, WAIT}) && !$past(ready, 2) |=> state == WAIT)
    else begin
      errors++;
      $display("[ERROR] %0t state left T3/WAIT while ready was low", $time);
    end

  assert property (@(posedge clk) disable iff (rst)
    (state inside {T3, WAIT}) && $past(ready, 2) |=> state != WAIT)
    else begin
      errors++;
      $display("[ERROR] %0t state entered or stayed in WAIT with ready seen", $time);
    end

  assert property (@(posedge clk) disable iff (rst) state == STOPPED |=> state == STOPPED)
    else begin
      errors++;
      $display("[ERROR] %0t state left STOPPED after HLT", $time);
    end

  assert property (@(posedge clk) disable iff (rst) sync == (state == T1))
    else begin
      errors++;
      $display("[ERROR] %0t sync is %0b in state %s", $time, sync, state.name());
    end

  task automatic report_and_finish(input bit timed_out);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: the core did not halt within %0d clock cycles", limit);
      report_and_finish(1'b1);
    end
  end

  initial begin
    void'($urandom(SEED));
    rst   = 1'b1;
    ready = 1'b1;
    d_in  = '0;
    for (int i = 0; i < MEM_SIZE; i++) begin
      mem[i] = 8'(i) ^ 8'(i >> 6);   // Unused bytes still differ per address
    end
    build_program();
    // Up to three machine cycles of five states each stretched by a stall
    limit = n_instr * 15 * (MAX_STALL + 3) + 100;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    wait (state == STOPPED);
    repeat (20) @(posedge clk);
    expect_eq("bus cycles never seen", bus_q.size(), 0);
    expect_eq("writes never seen", data_q.size(), 0);
    report_and_finish(1'b0);
  end

endmodule

`default_nettype wire

// ==== hdl/i8008_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i8008_top (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [i8008_core_pkg::DATA_W-1:0] d_in,
  input  logic                              ready,
  output logic [i8008_core_pkg::DATA_W-1:0] d_out,
  output logic                              sync,
  output i8008_core_pkg::state_t            state
);

  core_ctrl_if ctl ();

  i8008_sequencer u_sequencer (
    .clk   (clk),
    .rst   (rst),
    .ready (ready),
    .state (state),
    .sync  (sync),
    .ctl   (ctl.sequencer)
  );

  i8008_datapath u_datapath (
    .clk   (clk),
    .rst   (rst),
    .d_in  (d_in),
    .d_out (d_out),
    .ctl   (ctl.datapath)
  );

endmodule

`default_nettype wire

// ==== sequencer/i8008_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module i8008_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ready,
  output i8008_core_pkg::state_t state,
  output logic                   sync,
  core_ctrl_if.sequencer         ctl
);
  import i8008_core_pkg::*;
  import i8008_isa_pkg::*;

  logic              ready_meta;
  logic              ready_s;
  logic              capture;
  state_t            state_nx;
  cycle_t            cycle;
  cycle_t            cycle_nx;
  ctrl_t             c;
  logic [DATA_W-1:0] ir;
  logic [2:0]        sss;
  logic [2:0]        ddd;
  logic is_hlt, is_lmr, is_lrr, is_lri, is_alur, is_alui;
  logic is_inr, is_dcr, is_rot, is_jmp;

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_meta <= 1'b0;
      ready_s    <= 1'b0;
    end else begin
      ready_meta <= ready;
      ready_s    <= ready_meta;
    end
  end

  assign ir  = ctl.instr;
  assign sss = ir[2:0];
  assign ddd = ir[5:3];

  // HLT shares patterns with DCr, INr and Lr1r2, so it is masked out of them
  assign is_hlt  = (ir == OP_HLT0) || (ir == OP_HLT1) || (ir == OP_HLT2);
  assign is_lmr  = (ir ==? OP_LMR) && !is_hlt;
  assign is_lrr  = (ir ==? OP_LRR) && !is_lmr && !is_hlt;
  assign is_lri  = (ir ==? OP_LRI);
  assign is_alur = (ir ==? OP_ALUR);
  assign is_alui = (ir ==? OP_ALUI);
  assign is_inr  = (ir ==? OP_INR) && !is_hlt;
  assign is_dcr  = (ir ==? OP_DCR) && !is_hlt;
  assign is_rot  = (ir ==? OP_ROT);
  assign is_jmp  = (ir ==? OP_JMP);

  assign capture     = (state == T3 || state == WAIT) && ready_s;
  assign ctl.capture = capture;
  assign ctl.fetch   = capture && cycle == CYCLE1;
  assign ctl.ctrl    = c;
  assign sync        = (state == T1);

  always_comb begin
    c        = '0;
    state_nx = state;
    cycle_nx = cycle;
    case (state)
      T1: begin
        state_nx = T2;
        if (cycle == CYCLE1) begin
          c.pc.cyc = CYC_PCI;
        end else begin
          c.pc.cyc = is_lmr ? CYC_PCW : CYC_PCR;
        end
        if (cycle == CYCLE2 && is_lmr) begin // Write address high byte from H
          c.rf_re  = 1'b1;
          c.rf_sel = REG_H;
          c.dbr_hi = 1'b1;
        end else begin
          c.pc.re = 1'b1;
        end
      end
      T2: begin
        state_nx = T3;
        if (cycle == CYCLE2 && is_lmr) begin
          c.rf_re  = 1'b1; // Write data shows in T3
          c.rf_sel = sss;
          c.dbr_we = 1'b1;
        end else begin
          c.pc.inc = 1'b1;
          if (cycle == CYCLE1) begin
            c.rf_re  = 1'b1; // Accumulator into temp A for later ALU ops
            c.rf_sel = REG_A;
            c.a_we   = 1'b1;
          end
        end
      end
      T3, WAIT: begin
        if (!ready_s) begin
          state_nx = WAIT;
        end else if (cycle == CYCLE1) begin
          c.dbr_re = 1'b1;
          c.ir_we  = 1'b1;
          if (is_hlt) begin
            state_nx = STOPPED;
          end else if (is_lri || is_alui || is_jmp) begin
            state_nx    = T1;
            cycle_nx    = CYCLE2;
            c.pc.re     = 1'b1;
            c.pc.lower  = 1'b1;
          end else begin
            state_nx = T4;
          end
        end else if (cycle == CYCLE2 && is_lmr) begin
          state_nx   = T1;
          cycle_nx   = CYCLE1;
          c.pc.re    = 1'b1;
          c.pc.lower = 1'b1;
        end else if (cycle == CYCLE2) begin
          c.dbr_re = 1'b1; // Immediate byte or jump target low
          c.b_we   = 1'b1;
          if (is_jmp) begin
            state_nx   = T1;
            cycle_nx   = CYCLE3;
            c.pc.re    = 1'b1;
            c.pc.lower = 1'b1;
          end else begin
            state_nx = T4;
          end
        end else begin
          c.dbr_re = 1'b1; // Jump target high
          c.a_we   = 1'b1;
          state_nx = T4;
        end
      end
      T4: begin
        state_nx = T5;
        if (cycle == CYCLE3) begin
          c.a_re       = 1'b1;
          c.pc.load_hi = 1'b1;
        end else if (cycle == CYCLE1 && is_lmr) begin
          c.rf_re  = 1'b1; // Write address low byte from L
          c.rf_sel = REG_L;
          c.dbr_we = 1'b1;
          state_nx = T1;
          cycle_nx = CYCLE2;
        end else if (cycle == CYCLE1 && (is_lrr || is_alur)) begin
          c.rf_re  = 1'b1;
          c.rf_sel = sss;
          c.b_we   = 1'b1;
        end else if (cycle == CYCLE1 && (is_inr || is_dcr)) begin
          c.rf_re  = 1'b1;
          c.rf_sel = ddd;
          c.a_we   = 1'b1;
        end
      end
      T5: begin
        state_nx = T1;
        cycle_nx = CYCLE1;
        if (cycle == CYCLE3) begin
          c.b_re       = 1'b1; // Target low goes to the PC and to d_out together
          c.pc.load_lo = 1'b1;
          c.dbr_we     = 1'b1;
        end else begin
          c.pc.re    = 1'b1;
          c.pc.lower = 1'b1;
          if (is_lrr || is_lri) begin
            c.b_re   = 1'b1;
            c.rf_we  = 1'b1;
            c.rf_sel = ddd;
          end else if (is_alur || is_alui) begin
            c.alu.alu_op  = ddd;
            c.alu.re      = 1'b1;
            c.alu.flag_en = 1'b1;
            c.rf_we       = (ddd != ALU_CMP); // Compare only sets carry
            c.rf_sel      = REG_A;
          end else if (is_inr || is_dcr) begin
            c.alu.arith    = 1'b1;
            c.alu.arith_op = is_inr ? ARITH_INC : ARITH_DEC;
            c.alu.re       = 1'b1;
            c.alu.flag_en  = 1'b1;
            c.rf_we        = 1'b1;
            c.rf_sel       = ddd;
          end else if (is_rot) begin
            c.alu.arith    = 1'b1;
            c.alu.arith_op = ARITH_RLC + {1'b0, ir[4:3]};
            c.alu.re       = 1'b1;
            c.alu.flag_en  = 1'b1;
            c.rf_we        = 1'b1;
            c.rf_sel       = REG_A;
          end
        end
      end
      default: state_nx = STOPPED; // Only reset leaves
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= T1;
      cycle <= CYCLE1;
    end else begin
      state <= state_nx;
      cycle <= cycle_nx;
    end
  end

endmodule

`default_nettype wire

// ==== datapath/i8008_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module i8008_datapath (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [i8008_core_pkg::DATA_W-1:0] d_in,
  output logic [i8008_core_pkg::DATA_W-1:0] d_out,
  core_ctrl_if.datapath                     ctl
);
  import i8008_core_pkg::*;

  ctrl_t             c;
  logic [DATA_W-1:0] bus;
  logic [DATA_W-1:0] rx;       // Incoming byte, or the held one
  logic [DATA_W-1:0] rf_out;
  logic [DATA_W-1:0] alu_out;
  logic [DATA_W-1:0] pc_byte;
  logic [DATA_W-1:0] tmp_a;
  logic [DATA_W-1:0] tmp_b;
  logic [DATA_W-1:0] dbr;
  logic [DATA_W-1:0] ir;
  logic [DATA_W-1:0] regs [NUM_REGS];

  assign c      = ctl.ctrl;
  assign rx     = ctl.capture ? d_in : dbr;
  assign rf_out = (c.rf_sel < NUM_REGS) ? regs[c.rf_sel] : '0; // Code 7 is memory

  // One source per state
  always_comb begin
    if (c.rf_re) begin
      bus = rf_out;
    end else if (c.alu.re) begin
      bus = alu_out;
    end else if (c.a_re) begin
      bus = tmp_a;
    end else if (c.b_re) begin
      bus = tmp_b;
    end else if (c.dbr_re) begin
      bus = rx;
    end else begin
      bus = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (c.rf_we && c.rf_sel < NUM_REGS) begin
      regs[c.rf_sel] <= bus;
    end
    if (c.a_we) tmp_a <= bus;
    if (c.b_we) tmp_b <= bus;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ir <= '0;
    end else if (c.ir_we) begin
      ir <= bus;
    end
  end

  // Loaded one state ahead, so d_out holds the byte for the state that follows.
  // The address byte has its own path because T5 uses the bus for writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      dbr <= '0; // Address 0 is on d_out in the first T1
    end else if (c.pc.re) begin
      dbr <= pc_byte;
    end else if (ctl.capture) begin
      dbr <= d_in;
    end else if (c.dbr_hi) begin
      dbr <= {c.pc.cyc, bus[ADDR_HI_W-1:0]};
    end else if (c.dbr_we) begin
      dbr <= bus;
    end
  end

  assign d_out     = dbr;
  assign ctl.instr = ctl.fetch ? d_in : ir; // Decode sees the opcode as it arrives

  alu u_alu (
    .clk      (clk),
    .rst      (rst),
    .a        (tmp_a),
    .b        (tmp_b),
    .alu_ctrl (c.alu),
    .result   (alu_out),
    .carry    (ctl.carry)
  );

  program_counter u_pc (
    .clk     (clk),
    .rst     (rst),
    .bus     (bus),
    .pc_ctrl (c.pc),
    .pc_byte (pc_byte)
  );

endmodule

`default_nettype wire

// ==== datapath/program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module program_counter (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [i8008_core_pkg::DATA_W-1:0] bus,
  input  i8008_core_pkg::pc_ctrl_t          pc_ctrl,
  output logic [i8008_core_pkg::DATA_W-1:0] pc_byte
);
  import i8008_core_pkg::*;

  logic [ADDR_W-1:0] pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (pc_ctrl.load_hi) begin
      pc[ADDR_W-1:DATA_W] <= bus[ADDR_HI_W-1:0];
    end else if (pc_ctrl.load_lo) begin
      pc[DATA_W-1:0] <= bus;
    end else if (pc_ctrl.inc) begin
      pc <= pc + 1'b1;
    end
  end

  // T2 byte carries the cycle type above the high address bits
  assign pc_byte = pc_ctrl.lower ? pc[DATA_W-1:0] : {pc_ctrl.cyc, pc[ADDR_W-1:DATA_W]};

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [i8008_core_pkg::DATA_W-1:0]   a,
  input  logic [i8008_core_pkg::DATA_W-1:0]   b,
  input  i8008_core_pkg::alu_ctrl_t           alu_ctrl,
  output logic [i8008_core_pkg::DATA_W-1:0]   result,
  output logic                                carry
);
  import i8008_core_pkg::*;
  import i8008_isa_pkg::*;

  logic [DATA_W:0] sum; // Bit 8 is carry out or borrow
  logic            carry_nx;

  always_comb begin
    sum      = '0;
    carry_nx = carry;
    result   = a;
    if (alu_ctrl.arith) begin
      case (alu_ctrl.arith_op)
        ARITH_INC: result = a + 1'b1; // Carry untouched
        ARITH_DEC: result = a - 1'b1;
        ARITH_RLC: begin
          result   = {a[6:0], a[7]};
          carry_nx = a[7];
        end
        ARITH_RRC: begin
          result   = {a[0], a[7:1]};
          carry_nx = a[0];
        end
        ARITH_RAL: begin
          result   = {a[6:0], carry}; // Rotate through carry
          carry_nx = a[7];
        end
        ARITH_RAR: begin
          result   = {carry, a[7:1]};
          carry_nx = a[0];
        end
        default: result = a;
      endcase
    end else begin
      case (alu_ctrl.alu_op)
        ALU_ADD: sum = {1'b0, a} + {1'b0, b};
        ALU_ADC: sum = {1'b0, a} + {1'b0, b} + carry;
        ALU_SUB, ALU_CMP: sum = {1'b0, a} - {1'b0, b};
        ALU_SBB: sum = {1'b0, a} - {1'b0, b} - carry;
        ALU_ANA: sum = {1'b0, a & b};
        ALU_XRA: sum = {1'b0, a ^ b};
        default: sum = {1'b0, a | b}; // ORA
      endcase
      result   = sum[DATA_W-1:0];
      carry_nx = sum[DATA_W]; // Zero for the logic ops
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      carry <= 1'b0;
    end else if (alu_ctrl.flag_en) begin
      carry <= carry_nx;
    end
  end

endmodule

`default_nettype wire

// ==== common/core_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface core_ctrl_if;
  import i8008_core_pkg::*;

  ctrl_t             ctrl;
  logic              capture; // Byte on d_in is taken this cycle
  logic              fetch;   // Same, in the instruction fetch cycle
  logic [DATA_W-1:0] instr;
  logic              carry;

  modport sequencer (
    output ctrl,
    output capture,
    output fetch,
    input  instr,
    input  carry
  );

  modport datapath (
    input  ctrl,
    input  capture,
    input  fetch,
    output instr,
    output carry
  );
endinterface

`default_nettype wire

// ==== common/i8008_core_pkg.sv ====
`default_nettype none

package i8008_core_pkg;

  localparam int DATA_W    = 8;
  localparam int ADDR_W    = 14;
  localparam int ADDR_HI_W = 6;  // Address bits in the T2 byte
  localparam int NUM_REGS  = 7;

  typedef enum logic [2:0] {
    WAIT    = 3'b000,
    T3      = 3'b001,
    T1      = 3'b010,
    STOPPED = 3'b011,
    T2      = 3'b100,
    T5      = 3'b101,
    T4      = 3'b111
  } state_t;

  typedef enum logic [1:0] {
    CYCLE1 = 2'd0,
    CYCLE2 = 2'd1,
    CYCLE3 = 2'd2
  } cycle_t;

  typedef struct packed {
    logic       arith;    // Single-operand op instead of two-operand op
    logic [2:0] alu_op;
    logic [2:0] arith_op;
    logic       flag_en;
    logic       re;
  } alu_ctrl_t;

  typedef struct packed {
    logic       re;       // Address byte into the data-bus register
    logic       lower;    // Low byte, else type plus high bits
    logic [1:0] cyc;
    logic       inc;
    logic       load_hi;
    logic       load_lo;
  } pc_ctrl_t;

  typedef struct packed {
    logic       ir_we;
    logic       a_we;
    logic       a_re;
    logic       b_we;
    logic       b_re;
    logic       dbr_we;
    logic       dbr_hi;   // Load cycle type with the low bits of the bus
    logic       dbr_re;
    logic       rf_we;
    logic       rf_re;
    logic [2:0] rf_sel;
    alu_ctrl_t  alu;
    pc_ctrl_t   pc;
  } ctrl_t;

endpackage

`default_nettype wire

// ==== common/i8008_isa_pkg.sv ====
`default_nettype none

package i8008_isa_pkg;

  // Opcode match patterns, compared with ==? so that ? bits are don't-care
  localparam logic [7:0] OP_HLT0 = 8'b0000_0000;
  localparam logic [7:0] OP_HLT1 = 8'b0000_0001;
  localparam logic [7:0] OP_HLT2 = 8'b1111_1111;
  localparam logic [7:0] OP_LMR  = 8'b1111_1???; // 11 111 SSS
  localparam logic [7:0] OP_LRR  = 8'b11??_????; // 11 DDD SSS
  localparam logic [7:0] OP_LRI  = 8'b00??_?110; // 00 DDD 110
  localparam logic [7:0] OP_ALUR = 8'b10??_????; // 10 PPP SSS
  localparam logic [7:0] OP_ALUI = 8'b00??_?100; // 00 PPP 100
  localparam logic [7:0] OP_INR  = 8'b00??_?000;
  localparam logic [7:0] OP_DCR  = 8'b00??_?001;
  localparam logic [7:0] OP_ROT  = 8'b000?_?010; // RLC RRC RAL RAR
  localparam logic [7:0] OP_JMP  = 8'b01??_?100;

  // ALU ops, straight from instruction bits 5:3
  localparam logic [2:0] ALU_ADD = 3'b000;
  localparam logic [2:0] ALU_ADC = 3'b001;
  localparam logic [2:0] ALU_SUB = 3'b010;
  localparam logic [2:0] ALU_SBB = 3'b011;
  localparam logic [2:0] ALU_ANA = 3'b100;
  localparam logic [2:0] ALU_XRA = 3'b101;
  localparam logic [2:0] ALU_ORA = 3'b110;
  localparam logic [2:0] ALU_CMP = 3'b111;

  // Single-operand ops; rotates sit in the order of instruction bits 4:3
  localparam logic [2:0] ARITH_INC = 3'b000;
  localparam logic [2:0] ARITH_DEC = 3'b001;
  localparam logic [2:0] ARITH_RLC = 3'b010;
  localparam logic [2:0] ARITH_RRC = 3'b011;
  localparam logic [2:0] ARITH_RAL = 3'b100;
  localparam logic [2:0] ARITH_RAR = 3'b101;

  localparam logic [2:0] REG_A = 3'd0;
  localparam logic [2:0] REG_B = 3'd1;
  localparam logic [2:0] REG_C = 3'd2;
  localparam logic [2:0] REG_D = 3'd3;
  localparam logic [2:0] REG_E = 3'd4;
  localparam logic [2:0] REG_H = 3'd5;
  localparam logic [2:0] REG_L = 3'd6;
  localparam logic [2:0] REG_M = 3'd7; // Memory, not a scratchpad entry

  localparam logic [1:0] CYC_PCI = 2'b00; // Instruction fetch
  localparam logic [1:0] CYC_PCR = 2'b10; // Memory read
  localparam logic [1:0] CYC_PCW = 2'b11; // Memory write

endpackage

`default_nettype wire
